//--- sim.f
+incdir+.
cpu_pkg.sv
regfile.sv
stage_if.sv
stage_id.sv
stage_ex.sv
stage_mem.sv
cpu.sv
tb_cpu.sv

//--- Makefile
# Verilator build and run for the five-stage pipeline.

VERILATOR  ?= verilator
TOP        ?= tb_cpu
RTL_TOP    ?= cpu
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only
RTL_SRCS   ?= cpu_pkg.sv regfile.sv stage_if.sv stage_id.sv stage_ex.sv stage_mem.sv cpu.sv
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -I. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int ROM_WORDS = 512;
    localparam int RAM_WORDS = 64;

    logic  clock_i;
    logic  rst_n_i = 1'b0;
    word_t rom_addr_o;
    word_t rom_data_i = '0;
    logic  ram_read_o;
    logic  ram_write_o;
    word_t ram_addr_o;
    word_t ram_wdata_o;
    word_t ram_rdata_i = '0;

    word_t  rom [ROM_WORDS];
    word_t  ram [RAM_WORDS];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     prog_len;
    integer seed = 32'h56529694;
    string  cur_test = "none";
    logic   ram_fill = 1'b0;
    logic   running = 1'b0;
    int     store_idx = 0;                      // stores seen in the running test.
    int     store_errors = 0;
    int     check_errors = 0;
    int     cycle_count = 0;
    int     cycle_budget = 20;
    int     tests_run = 0;
    int     tests_failed = 0;

    cpu DUT (
        .clock_i     (clock_i    ),
        .rst_n_i     (rst_n_i    ),
        .rom_addr_o  (rom_addr_o ),
        .rom_data_i  (rom_data_i ),
        .ram_read_o  (ram_read_o ),
        .ram_write_o (ram_write_o),
        .ram_addr_o  (ram_addr_o ),
        .ram_wdata_o (ram_wdata_o),
        .ram_rdata_i (ram_rdata_i)
    );

    initial begin
        clock_i = 1'b0;
        forever #2 clock_i = ~clock_i;
    end

    //////////////////////////////////////////////////////////////////////
    // memory models and store checker

    function automatic word_t fill_word(input int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0101_0007);
    endfunction

    always @(negedge clock_i) begin
        rom_data_i  <= rom[rom_addr_o[10:2]];
        ram_rdata_i <= ram[ram_addr_o[7:2]];   // sees a store committed at the last edge.
    end

    always @(posedge clock_i) begin
        if (ram_fill) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= fill_word(i);
            end
        end else if (ram_write_o) begin
            ram[ram_addr_o[7:2]] <= ram_wdata_o;
        end
    end

    always @(posedge clock_i) begin
        if (!running) begin
            store_idx = 0;
        end else if (ram_write_o) begin
            if (store_idx >= exp_addr.size()) begin
                $display("ERROR: test %s wrote %h to address %h after its last expected store",
                         cur_test, ram_wdata_o, ram_addr_o);
                store_errors++;
            end else begin
                assert (ram_addr_o == exp_addr[store_idx] && ram_wdata_o == exp_data[store_idx])
                else begin
                    $display("CHECK FAILED %s: store %0d expected %h @ %h actual %h @ %h",
                             cur_test, store_idx, exp_data[store_idx], exp_addr[store_idx],
                             ram_wdata_o, ram_addr_o);
                    store_errors++;
                end
            end
            store_idx++;
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_budget) begin
            @(posedge clock_i);
            cycle_count++;
        end
        $display("ERROR: timeout in test %s with %0d of %0d stores seen",
                 cur_test, store_idx, exp_addr.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // program building

    function automatic int rand_below(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs, input int rt);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [5:0] pick_funct(input int k);
        case (k)
            0:       return `FN_ADDU;
            1:       return `FN_SUBU;
            2:       return `FN_AND;
            3:       return `FN_OR;
            4:       return `FN_XOR;
            5:       return `FN_NOR;
            6:       return `FN_SLT;
            default: return `FN_SLTU;
        endcase
    endfunction

    // one of the eight R-type or five I-type operations with destination d.
    function automatic word_t rand_alu(input int d, input int s, input int t);
        logic [15:0] imm;
        int          k;
        imm = 16'(rand_below(65536));
        k   = rand_below(13);
        case (k)
            8:       return enc_i(`OP_ADDIU, d, s, imm);
            9:       return enc_i(`OP_ANDI, d, s, imm);
            10:      return enc_i(`OP_ORI, d, s, imm);
            11:      return enc_i(`OP_XORI, d, s, imm);
            12:      return enc_i(`OP_LUI, d, s, imm);
            default: return enc_r(pick_funct(k), d, s, t);
        endcase
    endfunction

    task automatic emit(input word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        prog_len = 0;
        for (int r = 1; r <= 8; r++) begin
            emit(enc_i(`OP_ADDIU, r, 0, 16'(rand_below(65536))));
        end
    endtask

    task automatic dump_registers();
        for (int r = 0; r < 32; r++) begin
            emit(enc_i(`OP_SW, r, 0, 16'(128 + 4 * r)));  // upper half of the ram.
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model that executes the rom one instruction at a time

    function automatic void reference_stores(input int n);
        word_t      regs [32];
        word_t      mem [RAM_WORDS];
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      simm;
        logic [5:0] op;
        reg_addr_t  dst;
        logic       wr;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < n; i++) begin
            ins  = rom[i];
            op   = ins[31:26];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            dst  = (op == `OP_SPECIAL) ? ins[15:11] : ins[20:16];
            wr   = 1'b1;
            res  = '0;
            if (op == `OP_SPECIAL) begin
                case (ins[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_NOR:  res = ~(a | b);
                    `FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    `FN_SLTU: res = {31'd0, a < b};
                    default:  wr = 1'b0;
                endcase
            end else begin
                case (op)
                    `OP_ADDIU: res = simm + a;
                    `OP_ANDI:  res = a & {16'h0000, ins[15:0]};
                    `OP_ORI:   res = a | {16'h0000, ins[15:0]};
                    `OP_XORI:  res = a ^ {16'h0000, ins[15:0]};
                    `OP_LUI:   res = {ins[15:0], 16'h0000};
                    `OP_LW:    res = mem[addr[7:2]];
                    `OP_SW: begin
                        wr = 1'b0;
                        mem[addr[7:2]] = b;
                        exp_addr.push_back(addr);
                        exp_data.push_back(b);
                    end
                    default:   wr = 1'b0;
                endcase
            end
            if (wr && dst != '0) begin
                regs[dst] = res;
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // test runner

    // first_mem is the rom index of the first memory instruction.
    task automatic run_test(input string name, input bit check_reset, input int first_mem);
        int errs_before;
        int errs;
        cur_test    = name;
        errs_before = store_errors + check_errors;
        reference_stores(prog_len);
        cycle_budget += 2 * prog_len + 32;
        @(negedge clock_i);
        rst_n_i  = 1'b0;
        ram_fill = 1'b1;
        repeat (2) @(negedge clock_i);
        rst_n_i  = 1'b1;
        ram_fill = 1'b0;
        running  = 1'b1;
        if (check_reset) begin
            for (int t = 0; t < first_mem + 3; t++) begin
                assert (rom_addr_o == word_t'(4 * t)) else begin
                    $display("CHECK FAILED %s: rom_addr_o in cycle %0d expected %h actual %h",
                             name, t, word_t'(4 * t), rom_addr_o);
                    check_errors++;
                end
                assert (!ram_read_o && !ram_write_o) else begin
                    $display("CHECK FAILED %s: strobes in cycle %0d expected 00 actual %b%b",
                             name, t, ram_read_o, ram_write_o);
                    check_errors++;
                end
                @(negedge clock_i);
            end
        end
        while (store_idx < exp_addr.size()) begin
            @(negedge clock_i);
        end
        repeat (8) @(negedge clock_i);          // an extra store would show up here.
        running = 1'b0;
        errs = store_errors + check_errors - errs_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-9s %4d instructions %3d stores %0d errors",
                 name, prog_len, exp_addr.size(), errs);
    endtask

    initial begin : main
        int prev;
        int d;
        int x;
        clear_program();
        dump_registers();
        run_test("reset", 1'b1, 8);

        clear_program();
        prev = 1 + rand_below(8);
        for (int i = 0; i < 40; i++) begin
            d = 1 + rand_below(31);
            if (rand_below(2) == 0) begin
                emit(enc_r(pick_funct(rand_below(8)), d, prev, 1 + rand_below(31)));
            end else begin
                emit(enc_r(pick_funct(rand_below(8)), d, 1 + rand_below(31), prev));
            end
            prev = d;
        end
        dump_registers();
        run_test("rtype", 1'b0, 0);

        clear_program();
        prev = 1;
        for (int i = 0; i < 20; i++) begin
            d = 1 + rand_below(31);
            emit(enc_i(`OP_ADDIU, d, prev, {rand_below(2) == 0, 15'(rand_below(32768))}));
            prev = 1 + rand_below(31);
            x    = rand_below(6);
            if (x >= 4) begin
                emit(enc_r(x == 4 ? `FN_SLT : `FN_SLTU, prev, d, 1 + rand_below(31)));
            end else begin
                case (x)
                    0:       emit(enc_i(`OP_ANDI, prev, d, 16'(rand_below(65536))));
                    1:       emit(enc_i(`OP_ORI, prev, d, 16'(rand_below(65536))));
                    2:       emit(enc_i(`OP_XORI, prev, d, 16'(rand_below(65536))));
                    default: emit(enc_i(`OP_LUI, prev, d, 16'(rand_below(65536))));
                endcase
            end
        end
        dump_registers();
        run_test("itype", 1'b0, 0);

        clear_program();
        for (int i = 0; i < 15; i++) begin
            x = 1 + rand_below(31);
            d = 1 + rand_below(31);
            emit(enc_i(`OP_LW, x, 0, 16'(4 * rand_below(32))));
            case (rand_below(3))
                0:       emit(rand_alu(d, x, 1 + rand_below(31)));
                1:       emit(enc_r(pick_funct(rand_below(8)), d, 1 + rand_below(31), x));
                default: emit(enc_i(`OP_SW, x, 0, 16'(4 * rand_below(32))));
            endcase
        end
        dump_registers();
        run_test("loaduse", 1'b0, 0);

        clear_program();
        emit(enc_i(`OP_ADDIU, 0, 1, 16'h1234));
        emit(enc_r(`FN_ADDU, 2, 0, 0));
        emit(enc_r(`FN_OR, 0, 1, 2));
        emit(enc_r(`FN_NOR, 3, 0, 0));
        emit(enc_i(`OP_LW, 0, 0, 16'h0010));
        emit(enc_r(`FN_ADDU, 4, 0, 1));
        emit(enc_i(`OP_LUI, 0, 0, 16'hdead));
        emit(enc_i(`OP_ORI, 5, 0, 16'h0007));
        for (int i = 0; i < 4; i++) begin
            emit(rand_alu(0, 1 + rand_below(31), 1 + rand_below(31)));
            emit(enc_r(pick_funct(rand_below(8)), 1 + rand_below(31), 0, 1 + rand_below(31)));
        end
        dump_registers();
        run_test("reg0", 1'b0, 0);

        clear_program();
        for (int i = 0; i < 250; i++) begin
            x = rand_below(16);
            if (x < 10) begin
                emit(rand_alu(rand_below(32), rand_below(32), rand_below(32)));
            end else if (x < 12) begin
                emit(enc_i(`OP_LW, rand_below(32), 0, 16'(4 * rand_below(32))));
            end else if (x < 14) begin
                emit(enc_i(`OP_SW, rand_below(32), 0, 16'(4 * rand_below(32))));
            end else if (x == 14) begin
                emit(enc_r(6'h00, rand_below(32), rand_below(32), rand_below(32)));  // sll.
            end else begin
                emit(word_t'($random(seed)));
            end
        end
        dump_registers();
        run_test("random", 1'b0, 0);

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, store_errors + check_errors);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic  clock_i,
    input  logic  rst_n_i,
    output word_t rom_addr_o,
    input  word_t rom_data_i,
    output logic  ram_read_o,
    output logic  ram_write_o,
    output word_t ram_addr_o,
    output word_t ram_wdata_o,
    input  word_t ram_rdata_i
);

    logic      stall;
    word_t     id_instr;

    reg_addr_t rf_addr_a;
    reg_addr_t rf_addr_b;
    word_t     rf_data_a;
    word_t     rf_data_b;

    alu_op_e   ex_alu_op;
    mem_op_e   ex_mem_op;
    word_t     ex_operand_a;
    word_t     ex_operand_b;
    word_t     ex_store_data;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;

    logic      fwd_ex_en;
    logic      fwd_ex_load;
    reg_addr_t fwd_ex_addr;
    word_t     fwd_ex_data;

    mem_op_e   mem_mem_op;
    word_t     mem_result;
    word_t     mem_store_data;
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;

    logic      fwd_mem_en;
    reg_addr_t fwd_mem_addr;
    word_t     fwd_mem_data;

    logic      wb_wr_en;
    reg_addr_t wb_wr_addr;
    word_t     wb_wr_data;

    //////////////////////////////////////////////////////////////////////

    regfile regfile (
        .clock_i     (clock_i   ),
        .rst_n_i     (rst_n_i   ),
        .rd_addr_a_i (rf_addr_a ),
        .rd_addr_b_i (rf_addr_b ),
        .rd_data_a_o (rf_data_a ),
        .rd_data_b_o (rf_data_b ),
        .wr_en_i     (wb_wr_en  ),
        .wr_addr_i   (wb_wr_addr),
        .wr_data_i   (wb_wr_data)
    );

    stage_if stage_if (
        .clock_i    (clock_i   ),
        .rst_n_i    (rst_n_i   ),
        .stall_i    (stall     ),
        .rom_addr_o (rom_addr_o),
        .rom_data_i (rom_data_i),
        .id_instr_o (id_instr  )
    );

    stage_id stage_id (
        .clock_i         (clock_i      ),
        .rst_n_i         (rst_n_i      ),
        .instr_i         (id_instr     ),
        .rf_addr_a_o     (rf_addr_a    ),
        .rf_addr_b_o     (rf_addr_b    ),
        .rf_data_a_i     (rf_data_a    ),
        .rf_data_b_i     (rf_data_b    ),
        .fwd_ex_en_i     (fwd_ex_en    ),
        .fwd_ex_load_i   (fwd_ex_load  ),
        .fwd_ex_addr_i   (fwd_ex_addr  ),
        .fwd_ex_data_i   (fwd_ex_data  ),
        .fwd_mem_en_i    (fwd_mem_en   ),
        .fwd_mem_addr_i  (fwd_mem_addr ),
        .fwd_mem_data_i  (fwd_mem_data ),
        .stall_o         (stall        ),
        .ex_alu_op_o     (ex_alu_op    ),
        .ex_mem_op_o     (ex_mem_op    ),
        .ex_operand_a_o  (ex_operand_a ),
        .ex_operand_b_o  (ex_operand_b ),
        .ex_store_data_o (ex_store_data),
        .ex_wr_en_o      (ex_wr_en     ),
        .ex_wr_addr_o    (ex_wr_addr   )
    );

    stage_ex stage_ex (
        .clock_i      (clock_i       ),
        .rst_n_i      (rst_n_i       ),
        .alu_op_i     (ex_alu_op     ),
        .mem_op_i     (ex_mem_op     ),
        .operand_a_i  (ex_operand_a  ),
        .operand_b_i  (ex_operand_b  ),
        .store_data_i (ex_store_data ),
        .wr_en_i      (ex_wr_en      ),
        .wr_addr_i    (ex_wr_addr    ),
        .fwd_en_o     (fwd_ex_en     ),
        .fwd_load_o   (fwd_ex_load   ),
        .fwd_addr_o   (fwd_ex_addr   ),
        .fwd_data_o   (fwd_ex_data   ),
        .mem_op_o     (mem_mem_op    ),
        .result_o     (mem_result    ),
        .store_data_o (mem_store_data),
        .wr_en_o      (mem_wr_en     ),
        .wr_addr_o    (mem_wr_addr   )
    );

    stage_mem stage_mem (
        .clock_i      (clock_i       ),
        .rst_n_i      (rst_n_i       ),
        .mem_op_i     (mem_mem_op    ),
        .result_i     (mem_result    ),
        .store_data_i (mem_store_data),
        .wr_en_i      (mem_wr_en     ),
        .wr_addr_i    (mem_wr_addr   ),
        .ram_read_o   (ram_read_o    ),
        .ram_write_o  (ram_write_o   ),
        .ram_addr_o   (ram_addr_o    ),
        .ram_wdata_o  (ram_wdata_o   ),
        .ram_rdata_i  (ram_rdata_i   ),
        .fwd_en_o     (fwd_mem_en    ),
        .fwd_addr_o   (fwd_mem_addr  ),
        .fwd_data_o   (fwd_mem_data  ),
        .wb_wr_en_o   (wb_wr_en      ),
        .wb_wr_addr_o (wb_wr_addr    ),
        .wb_wr_data_o (wb_wr_data    )
    );

endmodule

//--- stage_mem.sv
`timescale 1ns/1ps

module stage_mem import cpu_pkg::*; (
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  mem_op_e   mem_op_i,
    input  word_t     result_i,
    input  word_t     store_data_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    output logic      ram_read_o,
    output logic      ram_write_o,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    input  word_t     ram_rdata_i,
    output logic      fwd_en_o,
    output reg_addr_t fwd_addr_o,
    output word_t     fwd_data_o,
    output logic      wb_wr_en_o,
    output reg_addr_t wb_wr_addr_o,
    output word_t     wb_wr_data_o
);

    word_t wb_value;

    assign ram_read_o  = (mem_op_i == MEM_LOAD);
    assign ram_write_o = (mem_op_i == MEM_STORE);   // the ram commits at the next edge.
    assign ram_addr_o  = result_i;
    assign ram_wdata_o = store_data_i;

    assign wb_value = ram_read_o ? ram_rdata_i : result_i;

    assign fwd_en_o   = wr_en_i;
    assign fwd_addr_o = wr_addr_i;
    assign fwd_data_o = wb_value;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_wr_en_o <= wr_en_i;
        end
    end

    always_ff @(posedge clock_i) begin
        wb_wr_addr_o <= wr_addr_i;
        wb_wr_data_o <= wb_value;
    end

endmodule

//--- stage_ex.sv
`timescale 1ns/1ps

module stage_ex import cpu_pkg::*; (
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  alu_op_e   alu_op_i,
    input  mem_op_e   mem_op_i,
    input  word_t     operand_a_i,
    input  word_t     operand_b_i,
    input  word_t     store_data_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    output logic      fwd_en_o,
    output logic      fwd_load_o,
    output reg_addr_t fwd_addr_o,
    output word_t     fwd_data_o,
    output mem_op_e   mem_op_o,
    output word_t     result_o,
    output word_t     store_data_o,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o
);

    word_t result;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result = operand_a_i + operand_b_i;   // also lw/sw address.
            ALU_SUB:  result = operand_a_i - operand_b_i;
            ALU_AND:  result = operand_a_i & operand_b_i;
            ALU_OR:   result = operand_a_i | operand_b_i;
            ALU_XOR:  result = operand_a_i ^ operand_b_i;
            ALU_NOR:  result = ~(operand_a_i | operand_b_i);
            ALU_SLT:  result = word_t'($signed(operand_a_i) < $signed(operand_b_i));
            ALU_SLTU: result = word_t'(operand_a_i < operand_b_i);
            ALU_LUI:  result = {operand_b_i[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // for a load this is only the address; decode stalls on a match instead.
    assign fwd_en_o   = wr_en_i;
    assign fwd_load_o = (mem_op_i == MEM_LOAD);
    assign fwd_addr_o = wr_addr_i;
    assign fwd_data_o = result;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            mem_op_o <= MEM_NONE;
            wr_en_o  <= 1'b0;
        end else begin
            mem_op_o <= mem_op_i;
            wr_en_o  <= wr_en_i;
        end
    end

    always_ff @(posedge clock_i) begin
        result_o     <= result;
        store_data_o <= store_data_i;
        wr_addr_o    <= wr_addr_i;
    end

endmodule

//--- stage_id.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module stage_id import cpu_pkg::*; (
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  word_t     instr_i,
    output reg_addr_t rf_addr_a_o,
    output reg_addr_t rf_addr_b_o,
    input  word_t     rf_data_a_i,
    input  word_t     rf_data_b_i,
    input  logic      fwd_ex_en_i,
    input  logic      fwd_ex_load_i,
    input  reg_addr_t fwd_ex_addr_i,
    input  word_t     fwd_ex_data_i,
    input  logic      fwd_mem_en_i,
    input  reg_addr_t fwd_mem_addr_i,
    input  word_t     fwd_mem_data_i,
    output logic      stall_o,
    output alu_op_e   ex_alu_op_o,
    output mem_op_e   ex_mem_op_o,
    output word_t     ex_operand_a_o,
    output word_t     ex_operand_b_o,
    output word_t     ex_store_data_o,
    output logic      ex_wr_en_o,
    output reg_addr_t ex_wr_addr_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  dest;
    word_t      imm;
    word_t      src_a;
    word_t      src_b;
    alu_op_e    alu_op;
    mem_op_e    mem_op;
    logic       is_valid;
    logic       is_rtype;
    logic       is_store;
    logic       use_a;
    logic       use_b;
    logic       imm_zext;
    logic       dec_wr_en;

    assign opcode = instr_i[31:26];
    assign rs     = instr_i[25:21];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];
    assign funct  = instr_i[5:0];

    //////////////////////////////////////////////////////////////////////
    // decode

    always_comb begin
        is_valid = 1'b1;
        alu_op   = ALU_ADD;
        if (opcode == `OP_SPECIAL) begin
            case (funct)
                `FN_ADDU: alu_op = ALU_ADD;
                `FN_SUBU: alu_op = ALU_SUB;
                `FN_AND:  alu_op = ALU_AND;
                `FN_OR:   alu_op = ALU_OR;
                `FN_XOR:  alu_op = ALU_XOR;
                `FN_NOR:  alu_op = ALU_NOR;
                `FN_SLT:  alu_op = ALU_SLT;
                `FN_SLTU: alu_op = ALU_SLTU;
                default:  is_valid = 1'b0;
            endcase
        end else begin
            case (opcode)
                `OP_ADDIU, `OP_LW, `OP_SW: alu_op = ALU_ADD;
                `OP_ANDI: alu_op = ALU_AND;
                `OP_ORI:  alu_op = ALU_OR;
                `OP_XORI: alu_op = ALU_XOR;
                `OP_LUI:  alu_op = ALU_LUI;
                default:  is_valid = 1'b0;
            endcase
        end
    end

    assign is_rtype  = (opcode == `OP_SPECIAL);
    assign is_store  = is_valid && (opcode == `OP_SW);
    assign mem_op    = !is_valid           ? MEM_NONE  :
                       (opcode == `OP_LW)  ? MEM_LOAD  :
                       is_store            ? MEM_STORE : MEM_NONE;
    assign use_a     = is_valid && (opcode != `OP_LUI);
    assign use_b     = is_valid && (is_rtype || is_store);  // rt is a source only here.
    assign dest      = is_rtype ? rd : rt;
    assign dec_wr_en = is_valid && !is_store && (dest != '0);
    assign imm_zext  = opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
    assign imm       = imm_zext ? {16'h0000, instr_i[15:0]} : {{16{instr_i[15]}}, instr_i[15:0]};

    //////////////////////////////////////////////////////////////////////
    // operand forwarding and load-use stall

    assign rf_addr_a_o = rs;
    assign rf_addr_b_o = rt;

    // the youngest producer wins; writeback is covered by the regfile bypass.
    function automatic word_t pick_operand(input reg_addr_t addr, input word_t rf_data);
        if (addr != '0 && fwd_ex_en_i && fwd_ex_addr_i == addr) begin
            return fwd_ex_data_i;
        end
        if (addr != '0 && fwd_mem_en_i && fwd_mem_addr_i == addr) begin
            return fwd_mem_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        src_a = pick_operand(rs, rf_data_a_i);
        src_b = pick_operand(rt, rf_data_b_i);
    end

    // load data only exists in the memory stage, so a dependent instruction waits one cycle.
    assign stall_o = fwd_ex_en_i && fwd_ex_load_i &&
                     ((use_a && fwd_ex_addr_i == rs) || (use_b && fwd_ex_addr_i == rt));

    //////////////////////////////////////////////////////////////////////
    // decode/execute register

    always_ff @(posedge clock_i) begin
        if (!rst_n_i || stall_o) begin
            ex_alu_op_o <= ALU_ADD;             // a bubble writes nothing.
            ex_mem_op_o <= MEM_NONE;
            ex_wr_en_o  <= 1'b0;
        end else begin
            ex_alu_op_o <= alu_op;
            ex_mem_op_o <= mem_op;
            ex_wr_en_o  <= dec_wr_en;
        end
    end

    always_ff @(posedge clock_i) begin
        ex_operand_a_o  <= src_a;
        ex_operand_b_o  <= is_rtype ? src_b : imm;
        ex_store_data_o <= src_b;
        ex_wr_addr_o    <= dest;
    end

endmodule

//--- stage_if.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module stage_if import cpu_pkg::*; (
    input  logic  clock_i,
    input  logic  rst_n_i,
    input  logic  stall_i,
    output word_t rom_addr_o,
    input  word_t rom_data_i,
    output word_t id_instr_o
);

    word_t pc;

    assign rom_addr_o = pc;                     // the rom answers within the same cycle.

    // pc and the fetch/decode register move together, so a stall replays
    // the same fetch on the next cycle.
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc         <= `CPU_RESET_PC;
            id_instr_o <= '0;                   // an all-zero word decodes as a no-op.
        end else if (!stall_i) begin
            pc         <= pc + `CPU_PC_STEP;
            id_instr_o <= rom_data_i;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module regfile import cpu_pkg::*; (
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  reg_addr_t rd_addr_a_i,
    input  reg_addr_t rd_addr_b_i,
    output word_t     rd_data_a_o,
    output word_t     rd_data_b_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;                          // register 0 is hard-wired to zero.
        end
        if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;                   // writeback data is visible in its own cycle.
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a_o = read_port(rd_addr_a_i);
        rd_data_b_o = read_port(rd_addr_b_i);
    end

endmodule

//--- cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]     word_t;      // data word or byte address.
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_WORD_W      32
`define CPU_REG_ADDR_W  5
`define CPU_REG_COUNT   32
`define CPU_RESET_PC    32'h0000_0000
`define CPU_PC_STEP     32'd4

//////////////////////////////////////////////////////////////////////
// primary opcodes, bits 31:26 of the instruction.
`define OP_SPECIAL      6'h00
`define OP_ADDIU        6'h09
`define OP_ANDI         6'h0c
`define OP_ORI          6'h0d
`define OP_XORI         6'h0e
`define OP_LUI          6'h0f
`define OP_LW           6'h23
`define OP_SW           6'h2b

//////////////////////////////////////////////////////////////////////
// function codes, bits 5:0, only meaningful under OP_SPECIAL.
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a
`define FN_SLTU         6'h2b

`endif
